/* flist.f */
src/rvIsaPkg.sv
src/coreTypesPkg.sv
src/instructionMemory.sv
src/registerFile.sv
src/immediateGen.sv
src/alu.sv
src/dataMemory.sv
src/coreControl.sv
src/rvCore.sv
tb/rvRefModel.sv
tb/tbRvCore.sv

/* src/alu.sv */
`default_nettype none

module alu (
    input  wire coreTypesPkg::wordT  a,      // rs1 data
    input  wire coreTypesPkg::wordT  b,      // rs2 data or immediate
    input  wire coreTypesPkg::aluOpE aluOp,
    output coreTypesPkg::wordT       result,
    output logic                     eq,     // a == b, for beq
    output logic                     lt      // signed a < b, for blt
);
    import coreTypesPkg::*;

    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                result = a + b;  // also load/store address
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << b[4:0];  // shamt is 5 bits on rv32
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // flags come straight from the operands, independent of aluOp
    assign eq = (a == b);
    assign lt = ($signed(a) < $signed(b));

endmodule

`default_nettype wire

/* src/coreControl.sv */
`default_nettype none

module coreControl (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 start,         // pulse, honored in IDLE or HALT
    input  wire rvIsaPkg::instrT      instr,
    input  wire coreTypesPkg::wordT   rs1Data,
    input  wire coreTypesPkg::wordT   rs2Data,
    input  wire coreTypesPkg::wordT   imm,
    input  wire coreTypesPkg::wordT   aluResult,
    input  wire logic                 eq,
    input  wire logic                 lt,
    input  wire coreTypesPkg::wordT   memRdata,
    output coreTypesPkg::wordT        pc,
    output logic                      fetchEn,
    output coreTypesPkg::regIdxT      rs1,
    output coreTypesPkg::regIdxT      rs2,
    output coreTypesPkg::regIdxT      rd,
    output logic                      regWe,
    output coreTypesPkg::wordT        regWd,
    output rvIsaPkg::immKindE         immKind,
    output coreTypesPkg::aluOpE       aluOp,
    output coreTypesPkg::wordT        aluB,
    output logic                      memWe,
    output coreTypesPkg::wordT        memWd,
    output logic                      halted,
    output logic                      retireValid,
    output coreTypesPkg::addrT        retirePc,
    output logic                      retireRdWe,
    output coreTypesPkg::regIdxT      retireRd,
    output coreTypesPkg::wordT        retireRdData,
    output logic                      retireMemWe,
    output coreTypesPkg::addrT        retireMemAddr,
    output coreTypesPkg::wordT        retireMemData
);
    import rvIsaPkg::*;
    import coreTypesPkg::*;

    typedef enum logic [1:0] {
        WB_ALU,  // arithmetic result
        WB_MEM,  // lw data
        WB_PC4   // jal link
    } wbSelE;

    runStateE state;
    opcodeT   opcode;
    funct3T   funct3;
    funct7T   funct7;
    logic     running;
    logic     isEbreak;
    logic     useImm;     // operand b from immediate
    logic     writesRd;
    logic     writesMem;
    logic     isBranch;   // beq or blt
    logic     isJal;
    logic     taken;
    wbSelE    wbSel;
    wordT     pcPlus4;
    wordT     pcTarget;
    wordT     nextPc;

    // fixed field positions
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign running  = (state == ST_RUN);
    assign isEbreak = (instr == EBREAK);
    assign fetchEn  = running;
    assign halted   = (state == ST_HALT);

    // decode, anything unrecognized falls through as a no-op
    always_comb begin
        immKind   = IMM_I;
        aluOp     = ALU_ADD;
        useImm    = 1'b0;
        writesRd  = 1'b0;
        writesMem = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        wbSel     = WB_ALU;
        case (opcode)
            OP_IMM: begin
                useImm = 1'b1;
                if (funct3 == F3_ADD) begin
                    writesRd = 1'b1;  // addi
                end else if ((funct3 == F3_SLL) && (funct7 == F7_ZERO)) begin
                    aluOp    = ALU_SLL;  // slli
                    writesRd = 1'b1;
                end
            end
            OP_REG: begin
                if ((funct3 == F3_ADD) && (funct7 == F7_ZERO)) begin
                    writesRd = 1'b1;  // add
                end else if ((funct3 == F3_ADD) && (funct7 == F7_SUB)) begin
                    aluOp    = ALU_SUB;
                    writesRd = 1'b1;
                end
            end
            OP_LOAD: begin
                useImm   = 1'b1;
                writesRd = (funct3 == F3_LW);
                wbSel    = WB_MEM;
            end
            OP_STORE: begin
                immKind   = IMM_S;
                useImm    = 1'b1;
                writesMem = (funct3 == F3_LW);
            end
            OP_BRANCH: begin
                immKind  = IMM_B;
                aluOp    = ALU_SUB;  // result unused, flags do the work
                isBranch = (funct3 == F3_BEQ) || (funct3 == F3_BLT);
            end
            OP_JAL: begin
                immKind  = IMM_J;
                isJal    = 1'b1;
                writesRd = 1'b1;
                wbSel    = WB_PC4;
            end
            default: begin
            end
        endcase
    end

    assign aluB  = useImm ? imm : rs2Data;
    assign memWd = rs2Data;  // sw data is always rs2
    assign regWe = running && writesRd;   // x0 target still reported
    assign memWe = running && writesMem;

    always_comb begin
        case (wbSel)
            WB_MEM:  regWd = memRdata;
            WB_PC4:  regWd = pcPlus4;
            default: regWd = aluResult;
        endcase
    end

    // next pc
    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;  // jal and branch share one adder
    assign taken    = isJal || (isBranch && ((funct3 == F3_BLT) ? lt : eq));
    assign nextPc   = taken ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_HALT: begin
                    if (start) begin
                        state <= ST_RUN;
                        pc    <= '0;  // registers and data keep their values
                    end
                end
                ST_RUN: begin
                    if (isEbreak) begin
                        state <= ST_HALT;  // pc parks on the ebreak
                    end else begin
                        pc <= nextPc;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // commit trace mirrors the executing instruction
    assign retireValid   = running && !isEbreak;
    assign retirePc      = pc;
    assign retireRdWe    = regWe;
    assign retireRd      = rd;
    assign retireRdData  = regWd;
    assign retireMemWe   = memWe;
    assign retireMemAddr = aluResult;
    assign retireMemData = memWd;

    // no compressed instructions, so a taken jump must land on a word
    targetAligned: assert property (@(posedge clk) disable iff (!rstN)
        (running && taken) |-> (pcTarget[1:0] == 2'b00))
        else $error("misaligned jump target %h from pc %h", pcTarget, pc);

endmodule

`default_nettype wire

/* src/coreTypesPkg.sv */
`default_nettype none

package coreTypesPkg;

    typedef logic [31:0] wordT;    // register and memory data
    typedef logic [31:0] addrT;    // byte address
    typedef logic [4:0]  regIdxT;  // x0..x31

    localparam regIdxT X0 = 5'd0;  // hardwired zero register

    // only what the supported instructions need
    typedef enum logic [1:0] {
        ALU_ADD,  // addi, add, lw/sw address
        ALU_SUB,  // sub, branch compare
        ALU_SLL   // slli
    } aluOpE;

    // core run state
    typedef enum logic [1:0] {
        ST_IDLE,  // after reset, waiting for start
        ST_RUN,   // one instruction per clock
        ST_HALT   // stopped by ebreak, start runs again
    } runStateE;

endpackage

`default_nettype wire

/* src/dataMemory.sv */
`default_nettype none

module dataMemory #(
    parameter int DMEM_WORDS = 64  // data words
) (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire coreTypesPkg::addrT addr,  // byte address from the ALU
    input  wire coreTypesPkg::wordT wd,
    input  wire logic               we,
    output coreTypesPkg::wordT      rd
);
    import coreTypesPkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    wordT             mem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;  // word index

    assign idx = addr[IDX_W+1:2];  // drop byte offset

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wd;  // sw only, full word
        end
    end

    assign rd = mem[idx];  // lw reads in the same cycle

    // word access only, no byte enables here
    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        we |-> (addr[1:0] == 2'b00))
        else $error("misaligned store to %h", addr);

endmodule

`default_nettype wire

/* src/immediateGen.sv */
`default_nettype none

module immediateGen (
    input  wire rvIsaPkg::instrT   instr,
    input  wire rvIsaPkg::immKindE immKind,
    output coreTypesPkg::wordT     imm
);
    import rvIsaPkg::*;

    // instr[31] is the sign bit in every format
    always_comb begin
        case (immKind)
            IMM_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_S: begin
                // split around rd field
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // bit 11 sits in instr[7], bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                // 20 bit offset, scrambled order
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/instructionMemory.sv */
`default_nettype none

module instructionMemory #(
    parameter int IMEM_WORDS = 256  // program words
) (
    input  wire logic                          clk,
    input  wire logic                          loadEn,    // write one program word
    input  wire logic [$clog2(IMEM_WORDS)-1:0] loadAddr,  // word index, not byte
    input  wire rvIsaPkg::instrT               loadData,
    input  wire logic                          fetchEn,   // core in RUN
    input  wire coreTypesPkg::wordT            pc,
    output rvIsaPkg::instrT                    instr
);
    import rvIsaPkg::*;

    localparam int IDX_W = $clog2(IMEM_WORDS);

    instrT mem [IMEM_WORDS];  // one entry per instruction word

    // load port, ignored while the core fetches
    always_ff @(posedge clk) begin
        if (loadEn && !fetchEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // pc is a byte address, the array holds words
    assign instr = mem[pc[IDX_W+1:2]];

    // loader and control must agree on who owns the store
    loadOutsideRun: assert property (@(posedge clk) loadEn |-> !fetchEn)
        else $error("program load while core is running");

    // a jump past the program would wrap onto the wrong word
    fetchInRange: assert property (@(posedge clk) fetchEn |-> (pc[31:2] < IMEM_WORDS))
        else $error("fetch beyond program store, pc %h", pc);

endmodule

`default_nettype wire

/* src/registerFile.sv */
`default_nettype none

module registerFile (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire coreTypesPkg::regIdxT rs1,
    input  wire coreTypesPkg::regIdxT rs2,
    input  wire coreTypesPkg::regIdxT rd,
    input  wire logic                 we,
    input  wire coreTypesPkg::wordT   wd,
    output coreTypesPkg::wordT        rs1Data,
    output coreTypesPkg::wordT        rs2Data
);
    import coreTypesPkg::*;

    wordT regs [32];  // x0 entry exists but is never written

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;  // all registers start at zero
            end
        end else if (we && (rd != X0)) begin
            regs[rd] <= wd;  // writes to x0 just vanish
        end
    end

    // combinational reads, x0 forced to zero
    assign rs1Data = (rs1 == X0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == X0) ? '0 : regs[rs2];

    // a retired write to x0 must leave it zero on the next cycle
    x0StaysZero: assert property (@(posedge clk) disable iff (!rstN)
        (we && (rd == X0)) |=> (regs[0] == '0))
        else $error("x0 changed after a write to it");

endmodule

`default_nettype wire

/* src/rvCore.sv */
`default_nettype none

module rvCore #(
    parameter int IMEM_WORDS = 256,  // program words
    parameter int DMEM_WORDS = 64    // data words
) (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic                          loadEn,
    input  wire logic [$clog2(IMEM_WORDS)-1:0] loadAddr,
    input  wire rvIsaPkg::instrT               loadData,
    input  wire logic                          start,
    output logic                               halted,
    output logic                               retireValid,
    output coreTypesPkg::addrT                 retirePc,
    output logic                               retireRdWe,
    output coreTypesPkg::regIdxT               retireRd,
    output coreTypesPkg::wordT                 retireRdData,
    output logic                               retireMemWe,
    output coreTypesPkg::addrT                 retireMemAddr,
    output coreTypesPkg::wordT                 retireMemData
);
    import rvIsaPkg::*;
    import coreTypesPkg::*;

    wordT    pc;
    instrT   instr;
    logic    fetchEn;
    regIdxT  rs1;
    regIdxT  rs2;
    regIdxT  rd;
    logic    regWe;
    wordT    regWd;
    wordT    rs1Data;
    wordT    rs2Data;
    immKindE immKind;
    wordT    imm;
    aluOpE   aluOp;
    wordT    aluB;
    wordT    aluResult;  // also the data memory address
    logic    eq;
    logic    lt;
    logic    memWe;
    wordT    memWd;
    wordT    memRdata;

    coreControl u_coreControl (
        .clk, .rstN, .start, .instr, .rs1Data, .rs2Data, .imm,
        .aluResult, .eq, .lt, .memRdata,
        .pc, .fetchEn, .rs1, .rs2, .rd, .regWe, .regWd,
        .immKind, .aluOp, .aluB, .memWe, .memWd, .halted,
        .retireValid, .retirePc, .retireRdWe, .retireRd, .retireRdData,
        .retireMemWe, .retireMemAddr, .retireMemData
    );

    instructionMemory #(.IMEM_WORDS(IMEM_WORDS)) u_instructionMemory (
        .clk, .loadEn, .loadAddr, .loadData, .fetchEn, .pc, .instr
    );

    registerFile u_registerFile (
        .clk, .rstN, .rs1, .rs2, .rd,
        .we(regWe), .wd(regWd), .rs1Data, .rs2Data
    );

    immediateGen u_immediateGen (.instr, .immKind, .imm);

    alu u_alu (.a(rs1Data), .b(aluB), .aluOp, .result(aluResult), .eq, .lt);

    dataMemory #(.DMEM_WORDS(DMEM_WORDS)) u_dataMemory (
        .clk, .rstN, .addr(aluResult), .wd(memWd), .we(memWe), .rd(memRdata)
    );

endmodule

`default_nettype wire

/* src/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] instrT;    // raw instruction word
    typedef logic [6:0]  opcodeT;   // instr[6:0]
    typedef logic [2:0]  funct3T;   // instr[14:12]
    typedef logic [6:0]  funct7T;   // instr[31:25]

    // major opcodes, only those this core decodes
    localparam opcodeT OP_IMM    = 7'b0010011;  // addi, slli
    localparam opcodeT OP_REG    = 7'b0110011;  // add, sub
    localparam opcodeT OP_LOAD   = 7'b0000011;  // lw
    localparam opcodeT OP_STORE  = 7'b0100011;  // sw
    localparam opcodeT OP_BRANCH = 7'b1100011;  // beq, blt
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_SYSTEM = 7'b1110011;  // ebreak lives here

    localparam funct3T F3_ADD = 3'b000;  // add and sub share it
    localparam funct3T F3_SLL = 3'b001;
    localparam funct3T F3_BEQ = 3'b000;
    localparam funct3T F3_BLT = 3'b100;
    localparam funct3T F3_LW  = 3'b010;  // word width, sw uses the same code

    localparam funct7T F7_ZERO = 7'b0000000;
    localparam funct7T F7_SUB  = 7'b0100000;  // sub, and srai on a full core

    // ebreak has no operands, so the whole word is matched
    localparam instrT EBREAK = 32'h0010_0073;

    // immediate encodings
    typedef enum logic [1:0] {
        IMM_I,  // addi, slli, lw
        IMM_S,  // sw
        IMM_B,  // beq, blt
        IMM_J   // jal
    } immKindE;

endpackage

`default_nettype wire

/* tb/rvRefModel.sv */
`default_nettype none

module rvRefModel #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 64
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // one expected retire record
    typedef struct packed {
        logic [31:0] pc;
        logic        rdWe;
        logic [4:0]  rd;
        logic [31:0] rdData;
        logic        memWe;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } commitT;

    logic [31:0] prog [IMEM_WORDS];  // copy of what was loaded
    logic [31:0] regs [32];          // survives between programs, like the core
    logic [31:0] dmem [DMEM_WORDS];
    commitT      expQ [$];           // expected commits, in order

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;  // matches the core after reset
        end
    end

    task automatic loadWord(input int idx, input logic [31:0] word);
        prog[idx] = word;
    endtask

    function automatic int pending();
        return expQ.size();
    endfunction

    // architectural execution from pc 0 until ebreak
    task automatic execute();
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nextPc;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [2:0]  f3;
        logic [6:0]  f7;
        commitT      c;
        int          steps;
        pc = '0;
        for (steps = 0; steps < 4 * IMEM_WORDS; steps++) begin
            ins = prog[(pc >> 2) % IMEM_WORDS];
            if (ins == EBREAK_WORD) begin
                break;  // halts, no commit
            end
            f3   = ins[14:12];
            f7   = ins[31:25];
            a    = regs[ins[19:15]];
            b    = regs[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            c        = '0;
            c.pc     = pc;
            c.rd     = ins[11:7];
            nextPc   = pc + 32'd4;
            case (ins[6:0])
                7'h13: begin  // addi, slli
                    if (f3 == 3'b000) begin
                        c.rdWe   = 1'b1;
                        c.rdData = a + immI;
                    end else if ((f3 == 3'b001) && (f7 == 7'h00)) begin
                        c.rdWe   = 1'b1;
                        c.rdData = a << ins[24:20];
                    end
                end
                7'h33: begin  // add, sub
                    if ((f3 == 3'b000) && (f7 == 7'h00)) begin
                        c.rdWe   = 1'b1;
                        c.rdData = a + b;
                    end else if ((f3 == 3'b000) && (f7 == 7'h20)) begin
                        c.rdWe   = 1'b1;
                        c.rdData = a - b;
                    end
                end
                7'h03: begin
                    if (f3 == 3'b010) begin  // lw
                        c.rdWe   = 1'b1;
                        c.rdData = dmem[((a + immI) >> 2) % DMEM_WORDS];
                    end
                end
                7'h23: begin
                    if (f3 == 3'b010) begin  // sw
                        c.memWe   = 1'b1;
                        c.memAddr = a + immS;
                        c.memData = b;
                    end
                end
                7'h63: begin
                    if ((f3 == 3'b000) && (a == b)) begin
                        nextPc = pc + immB;  // beq taken
                    end else if ((f3 == 3'b100) && ($signed(a) < $signed(b))) begin
                        nextPc = pc + immB;  // blt taken
                    end
                end
                7'h6f: begin  // jal links pc+4
                    c.rdWe   = 1'b1;
                    c.rdData = pc + 32'd4;
                    nextPc   = pc + immJ;
                end
                default: begin
                end
            endcase
            if (c.rdWe && (c.rd != 5'd0)) begin
                regs[c.rd] = c.rdData;  // x0 stays zero
            end
            if (c.memWe) begin
                dmem[(c.memAddr >> 2) % DMEM_WORDS] = c.memData;
            end
            expQ.push_back(c);
            pc = nextPc;
        end
    endtask

    task automatic popCommit(
        output logic [31:0] pc,
        output logic        rdWe,
        output logic [4:0]  rd,
        output logic [31:0] rdData,
        output logic        memWe,
        output logic [31:0] memAddr,
        output logic [31:0] memData
    );
        commitT c;
        c       = expQ.pop_front();
        pc      = c.pc;
        rdWe    = c.rdWe;
        rd      = c.rd;
        rdData  = c.rdData;
        memWe   = c.memWe;
        memAddr = c.memAddr;
        memData = c.memData;
    endtask

endmodule

`default_nettype wire

/* tb/tbRvCore.sv */
`default_nettype none

module tbRvCore;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 64;
    localparam int ADDR_W       = $clog2(IMEM_WORDS);
    localparam int CLK_PERIOD   = 100;
    localparam int PROG_LEN     = 32;  // body words, ebreak follows
    localparam int NUM_RANDOM   = 12;
    localparam int NUM_PROGRAMS = NUM_RANDOM + 1;  // loop program first
    localparam int SEED         = 93;
    localparam int BASE_REG     = 28;  // written only by memory setup addi
    // load plus run per program, plus slack; one extra slot for reset and idle
    localparam longint TIMEOUT_NS =
        longint'(NUM_PROGRAMS + 1) * (2 * PROG_LEN + 20) * CLK_PERIOD;

    localparam logic [6:0]  OP_IMM      = 7'h13;
    localparam logic [6:0]  OP_REG      = 7'h33;
    localparam logic [6:0]  OP_LOAD     = 7'h03;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic              clk = 1'b0;
    logic              rstN;
    logic              loadEn;
    logic [ADDR_W-1:0] loadAddr;
    logic [31:0]       loadData;
    logic              start;
    logic              halted;
    logic              retireValid;
    logic [31:0]       retirePc;
    logic              retireRdWe;
    logic [4:0]        retireRd;
    logic [31:0]       retireRdData;
    logic              retireMemWe;
    logic [31:0]       retireMemAddr;
    logic [31:0]       retireMemData;
    logic [31:0]       prog [$];  // program under construction
    int                errors = 0;

    rvCore #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) u_rvCore (
        .clk, .rstN, .loadEn, .loadAddr, .loadData, .start, .halted,
        .retireValid, .retirePc, .retireRdWe, .retireRd, .retireRdData,
        .retireMemWe, .retireMemAddr, .retireMemData
    );

    rvRefModel #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) u_refModel ();

    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction encoders, field order per format
    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, OP_REG};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic failRun();
        errors++;
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            failRun();
        end
    endtask

    // nothing may retire or write before start
    task automatic checkIdle();
        repeat (4) begin
            @(negedge clk);
            checkValue("halted", 32'd0, halted);
            checkValue("retireValid", 32'd0, retireValid);
            checkValue("retireRdWe", 32'd0, retireRdWe);
            checkValue("retireMemWe", 32'd0, retireMemWe);
        end
    endtask

    // count x1 up to x2, backward blt closes the loop
    task automatic buildLoopProgram();
        prog.delete();
        prog.push_back(encI(12'd0, 5'd0, 3'b000, 5'd1, OP_IMM));
        prog.push_back(encI(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));
        prog.push_back(encI(12'd1, 5'd1, 3'b000, 5'd1, OP_IMM));
        prog.push_back(encB(-13'sd4, 5'd2, 5'd1, 3'b100));
        prog.push_back(EBREAK_WORD);
    endtask

    task automatic genRandomProgram();
        int kind;
        int k;
        int rd;
        int rs1;
        int rs2;
        int base;
        int off;
        prog.delete();
        while (prog.size() < PROG_LEN) begin
            kind = $urandom_range(9);
            rd   = $urandom_range(BASE_REG - 1);  // x0 allowed, base reg never
            rs1  = $urandom_range(31);
            rs2  = $urandom_range(31);
            // forward only, never past the closing ebreak
            k    = $urandom_range((PROG_LEN - prog.size() < 4) ? PROG_LEN - prog.size() : 4, 1);
            if ((kind >= 4) && (kind <= 5) && (PROG_LEN - prog.size() >= 3)) begin
                base = $urandom_range(DMEM_WORDS / 2 - 1) * 4;
                off  = $urandom_range(DMEM_WORDS / 2 - 1) * 4;  // base + off stays in range
                prog.push_back(encI(12'(base), 5'd0, 3'b000, 5'(BASE_REG), OP_IMM));
                prog.push_back(encS(12'(off), 5'(rs2), 5'(BASE_REG)));
                if ($urandom_range(1) == 1) begin
                    off = $urandom_range(DMEM_WORDS / 2 - 1) * 4;  // read some other word
                end
                prog.push_back(encI(12'(off), 5'(BASE_REG), 3'b010, 5'(rd), OP_LOAD));
            end else if ((kind == 6) || (kind == 7)) begin
                prog.push_back(encB(13'(k * 4), 5'(rs2), 5'(rs1), (kind == 6) ? 3'b000 : 3'b100));
            end else if (kind == 8) begin
                prog.push_back(encJ(21'(k * 4), 5'(rd)));
            end else begin
                case ($urandom_range(3))
                    0: prog.push_back(encI(12'($urandom), 5'(rs1), 3'b000, 5'(rd), OP_IMM));
                    1: prog.push_back(encI({7'd0, 5'($urandom_range(31))}, 5'(rs1), 3'b001,
                                           5'(rd), OP_IMM));  // slli
                    2: prog.push_back(encR(7'h00, 5'(rs2), 5'(rs1), 5'(rd)));
                    default: prog.push_back(encR(7'h20, 5'(rs2), 5'(rs1), 5'(rd)));
                endcase
            end
        end
        prog.push_back(EBREAK_WORD);
    endtask

    // compare every commit until the core halts
    task automatic watchCommits();
        logic [31:0] ePc;
        logic        eRdWe;
        logic [4:0]  eRd;
        logic [31:0] eRdData;
        logic        eMemWe;
        logic [31:0] eMemAddr;
        logic [31:0] eMemData;
        bit          done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (retireValid && (u_refModel.pending() == 0)) begin
                $display("core committed pc %h at %0t ns but no commit was expected",
                         retirePc, $time);
                failRun();
            end else if (retireValid) begin
                u_refModel.popCommit(ePc, eRdWe, eRd, eRdData, eMemWe, eMemAddr, eMemData);
                checkValue("retirePc", ePc, retirePc);
                checkValue("retireRdWe", eRdWe, retireRdWe);
                checkValue("retireMemWe", eMemWe, retireMemWe);
                if (eRdWe) begin
                    checkValue("retireRd", eRd, retireRd);
                    checkValue("retireRdData", eRdData, retireRdData);
                end
                if (eMemWe) begin
                    checkValue("retireMemAddr", eMemAddr, retireMemAddr);
                    checkValue("retireMemData", eMemData, retireMemData);
                end
            end
            if (halted && (u_refModel.pending() != 0)) begin
                $display("core halted at %0t ns with %0d commits still expected",
                         $time, u_refModel.pending());
                failRun();
            end else if (halted) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic loadAndRun();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= ADDR_W'(i);  // word index
            loadData <= prog[i];
            u_refModel.loadWord(i, prog[i]);
        end
        @(posedge clk);
        loadEn <= 1'b0;
        start  <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;  // run starts from pc 0
        u_refModel.execute();
        watchCommits();
    endtask

    initial begin
        void'($urandom(SEED));  // seeds this thread once
        rstN     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        start    = 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        checkIdle();
        buildLoopProgram();
        loadAndRun();
        // each run inherits registers and data from the one before
        for (int p = 0; p < NUM_RANDOM; p++) begin
            genRandomProgram();
            loadAndRun();
        end
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        errors++;
        $display("watchdog expired after %0d ns, the core never finished its programs",
                 TIMEOUT_NS);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
